// ==== mips_pipe.f ====
+incdir+hdl
hdl/mips_pkg.sv
hdl/instr_decode.sv
hdl/id_ex_regs.sv
hdl/alu_execute.sv
hdl/result_stage.sv
hdl/mips_pipe.sv
test/mips_pipe_tb.sv

// ==== test/mips_pipe_tb.sv ====
`default_nettype none

`include "mips_settings.svh"

module mips_pipe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ISSUE_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 200;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    cpu_en;
    logic [`MIPS_DATA_W-1:0] instr;
    logic                    hold;
    mips_pkg::reg_write_t    wb;

    logic [`MIPS_DATA_W-1:0] model_regs [`MIPS_REG_COUNT];
    mips_pkg::reg_write_t    exp_q [$];
    int                      issue_q [$];  // cycle on which each expected result was issued
    logic [31:0]             rng = 32'h4cb9;
    int                      cycle = 0;
    int                      error_count = 0;
    int                      tests_run = 0;
    int                      tests_failed = 0;
    int                      test_start_errors = 0;
    int                      low_run = 0;
    bit                      freeze_mode = 0;
    bit                      latency_check = 0;

    mips_pipe mips_pipe_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .cpu_en (cpu_en),
        .instr  (instr),
        .hold   (hold),
        .wb     (wb)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // sequential meaning of one instruction against the model registers
    function automatic mips_pkg::reg_write_t expected_write(input logic [31:0] word);
        mips_pkg::reg_write_t w;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        op   = word[31:26];
        fn   = word[5:0];
        a    = model_regs[word[25:21]];
        b    = model_regs[word[20:16]];
        sext = {{16{word[15]}}, word[15:0]};
        zext = {16'h0000, word[15:0]};
        w    = '0;
        w.wr_en = 1'b1;
        if (op == mips_pkg::OP_RTYPE) begin
            w.wr_addr = word[15:11];
            case (fn)
                mips_pkg::FN_ADD: w.data = a + b;
                mips_pkg::FN_SUB: w.data = a - b;
                mips_pkg::FN_AND: w.data = a & b;
                mips_pkg::FN_OR:  w.data = a | b;
                mips_pkg::FN_XOR: w.data = a ^ b;
                mips_pkg::FN_SLT: w.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                mips_pkg::FN_SLL: w.data = b << word[10:6];
                mips_pkg::FN_SRL: w.data = b >> word[10:6];
                default:          w.wr_en = 1'b0;
            endcase
        end else begin
            w.wr_addr = word[20:16]; // immediates write rt
            case (op)
                mips_pkg::OP_ADDI: w.data = a + sext;
                mips_pkg::OP_ANDI: w.data = a & zext;
                mips_pkg::OP_ORI:  w.data = a | zext;
                default:           w.wr_en = 1'b0;
            endcase
        end
        if (w.wr_addr == '0) w.wr_en = 1'b0;
        return w;
    endfunction

    // kind 0 is R-type, 1 is I-type, 2 picks either
    task automatic random_instr(input int kind, output logic [31:0] word);
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [5:0] code;
        rng = xorshift32(rng);
        rs  = 5'(1 + rng % 7);
        rng = xorshift32(rng);
        rt  = 5'(1 + rng % 7);
        rng = xorshift32(rng);
        rd  = 5'(1 + rng % 7);
        rng = xorshift32(rng);
        if (kind == 0 || (kind == 2 && rng[8])) begin
            case (rng[2:0])
                3'd0: code = mips_pkg::FN_ADD;
                3'd1: code = mips_pkg::FN_SUB;
                3'd2: code = mips_pkg::FN_AND;
                3'd3: code = mips_pkg::FN_OR;
                3'd4: code = mips_pkg::FN_XOR;
                3'd5: code = mips_pkg::FN_SLT;
                3'd6: code = mips_pkg::FN_SLL;
                default: code = mips_pkg::FN_SRL;
            endcase
            word = rtype(code, rs, rt, rd, rng[15:11]);
        end else begin
            case (rng % 3)
                0: code = mips_pkg::OP_ADDI;
                1: code = mips_pkg::OP_ANDI;
                default: code = mips_pkg::OP_ORI;
            endcase
            word = itype(code, rs, rt, rng[31:16]);
        end
    endtask

    // enters and leaves 2 ns after a rising edge
    task automatic issue_instr(input logic [31:0] word, output int holds);
        mips_pkg::reg_write_t exp;
        int                   waited;
        bit                   consumed;
        holds    = 0;
        waited   = 0;
        consumed = 0;
        instr    = word;
        while (!consumed && waited < ISSUE_TIMEOUT) begin
            rng = xorshift32(rng);
            if (!freeze_mode) begin
                cpu_en = 1'b1;
            end else if (low_run > 0) begin
                cpu_en  = 1'b0;
                low_run = low_run - 1;
            end else if (rng[2:0] == 3'd0) begin
                cpu_en  = 1'b0;
                low_run = rng[5:4]; // a run of one to four frozen cycles
            end else begin
                cpu_en = 1'b1;
            end
            @(negedge clk);
            if (cpu_en && !hold) consumed = 1;
            else if (cpu_en) holds++;
            @(posedge clk);
            if (consumed) begin
                exp = expected_write(word);
                if (exp.wr_en) begin
                    model_regs[exp.wr_addr] = exp.data;
                    exp_q.push_back(exp);
                    issue_q.push_back(cycle);
                end
            end
            #2;
            waited++;
        end
        if (!consumed) begin
            $display("instruction %h was never taken by the pipeline", word);
            error_count++;
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        cpu_en = 1'b1;
        instr  = '0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected results never appeared on wb", exp_q.size());
            error_count++;
            exp_q.delete();
            issue_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        drain_results();
        errs = error_count - test_start_errors;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("test %s: %s (%0d errors)", name, (errs == 0) ? "ok" : "failed", errs);
        test_start_errors = error_count;
    endtask

    task automatic check_idle();
        assert (wb.wr_en == 1'b0) else begin
            $display("[ERROR] wb.wr_en got %h expected %h", wb.wr_en, 1'b0);
            error_count++;
        end
        assert (hold == 1'b0) else begin
            $display("[ERROR] hold got %h expected %h", hold, 1'b0);
            error_count++;
        end
    endtask

    task automatic expect_holds(input int got, input int want);
        assert (got == want) else begin
            $display("[ERROR] hold cycles got %h expected %h", got, want);
            error_count++;
        end
    endtask

    always @(negedge clk) begin : compare
        mips_pkg::reg_write_t exp;
        int                   issued;
        if (rst_n) begin
            assert (cpu_en || !wb.wr_en) else begin
                $display("a write event appeared on wb while cpu_en was low");
                error_count++;
            end
            if (wb.wr_en && exp_q.size() == 0) begin
                $display("unexpected write event to register %0d", wb.wr_addr);
                error_count++;
            end else if (wb.wr_en) begin
                exp    = exp_q.pop_front();
                issued = issue_q.pop_front();
                assert (wb.wr_addr == exp.wr_addr) else begin
                    $display("[ERROR] wb.wr_addr got %h expected %h", wb.wr_addr, exp.wr_addr);
                    error_count++;
                end
                assert (wb.data == exp.data) else begin
                    $display("[ERROR] wb.data got %h expected %h", wb.data, exp.data);
                    error_count++;
                end
                if (latency_check) begin
                    assert (cycle - issued == 2) else begin
                        $display("result for register %0d took %0d cycles instead of 2",
                                 wb.wr_addr, cycle - issued);
                        error_count++;
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] word;
        int          h;
        rst_n  = 1'b0;
        cpu_en = 1'b1; // enabled so that wb.wr_en is not masked while reset is checked
        instr  = '0;
        foreach (model_regs[i]) model_regs[i] = '0;

        repeat (3) begin
            @(posedge clk);
            #1;
            check_idle();
        end
        #1;
        rst_n  = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle();
            @(posedge clk);
            #2;
        end
        latency_check = 1;
        issue_instr(rtype(mips_pkg::FN_OR, 5'd2, 5'd3, 5'd1, 5'd0), h); // all registers still 0
        end_test("reset");

        for (int r = 1; r < 8; r++) begin
            rng = xorshift32(rng);
            issue_instr(itype(mips_pkg::OP_ADDI, 5'd0, 5'(r), rng[15:0]), h);
        end
        repeat (40) begin
            random_instr(0, word);
            issue_instr(word, h);
        end
        end_test("r-type");

        issue_instr(itype(mips_pkg::OP_ADDI, 5'd2, 5'd1, 16'h8001), h);
        issue_instr(itype(mips_pkg::OP_ANDI, 5'd4, 5'd3, 16'hf0f0), h);
        issue_instr(itype(mips_pkg::OP_ORI, 5'd6, 5'd5, 16'h8000), h);
        repeat (30) begin
            random_instr(1, word);
            issue_instr(word, h);
        end
        end_test("immediate");

        issue_instr(itype(mips_pkg::OP_ADDI, 5'd2, 5'd1, 16'h0011), h);
        issue_instr(rtype(mips_pkg::FN_SUB, 5'd1, 5'd3, 5'd4, 5'd0), h);
        expect_holds(h, 1);
        issue_instr(itype(mips_pkg::OP_ORI, 5'd5, 5'd6, 16'h00ff), h);
        issue_instr(rtype(mips_pkg::FN_XOR, 5'd7, 5'd7, 5'd2, 5'd0), h);
        expect_holds(h, 0);
        issue_instr(rtype(mips_pkg::FN_ADD, 5'd6, 5'd6, 5'd5, 5'd0), h); // two slots behind
        expect_holds(h, 0);
        issue_instr(itype(mips_pkg::OP_ADDI, 5'd0, 5'd3, 16'h0003), h);
        issue_instr(rtype(mips_pkg::FN_SLL, 5'd0, 5'd3, 5'd4, 5'd2), h);
        expect_holds(h, 1);
        issue_instr(itype(mips_pkg::OP_ADDI, 5'd0, 5'd5, 16'h0007), h);
        issue_instr(rtype(mips_pkg::FN_SRL, 5'd5, 5'd2, 5'd6, 5'd1), h); // rs is not read
        expect_holds(h, 0);
        end_test("hazard");

        latency_check = 0;
        freeze_mode   = 1;
        repeat (40) begin
            random_instr(2, word);
            issue_instr(word, h);
        end
        freeze_mode = 0;
        end_test("freeze");

        latency_check = 1;
        issue_instr(itype(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'h1234), h);
        issue_instr(rtype(mips_pkg::FN_ADD, 5'd1, 5'd2, 5'd0, 5'd0), h);
        issue_instr(32'h0000_0000, h);
        issue_instr(32'hfc22_0001, h); // opcode 0x3f is not supported
        issue_instr(rtype(6'h3f, 5'd1, 5'd2, 5'd3, 5'd0), h);
        issue_instr(rtype(mips_pkg::FN_OR, 5'd0, 5'd0, 5'd5, 5'd0), h);
        issue_instr(itype(mips_pkg::OP_ADDI, 5'd0, 5'd6, 16'h0000), h);
        end_test("register 0 and nops");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/mips_pipe.sv ====
`default_nettype none

`include "mips_settings.svh"

module mips_pipe (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            cpu_en,
    input  wire   [`MIPS_DATA_W-1:0]       instr,
    output logic                           hold,
    output mips_pkg::reg_write_t           wb
);

    mips_pkg::id_ex_t     id_out;
    mips_pkg::id_ex_t     ex_in;
    mips_pkg::reg_write_t ex_result;
    logic                 stall;

    instr_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .wb         (wb),
        .ex_wr_en   (ex_in.wr_en),
        .ex_wr_addr (ex_in.wr_addr),
        .id_out     (id_out),
        .stall      (stall)
    );

    id_ex_regs u_id_ex (
        .clk    (clk),
        .rst_n  (rst_n),
        .cpu_en (cpu_en),
        .stall  (stall),
        .id_out (id_out),
        .ex_in  (ex_in)
    );

    alu_execute u_execute (
        .ex_in     (ex_in),
        .ex_result (ex_result)
    );

    result_stage u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_en    (cpu_en),
        .ex_result (ex_result),
        .wb        (wb)
    );

    // the source presents the same word again while decode stalls
    assign hold = stall;

endmodule

`default_nettype wire

// ==== hdl/result_stage.sv ====
`default_nettype none

module result_stage (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            cpu_en,
    input  wire    mips_pkg::reg_write_t   ex_result,
    output mips_pkg::reg_write_t           wb
);

    mips_pkg::reg_write_t held;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= '0;
        end else if (cpu_en) begin
            held <= ex_result;
        end
    end

    // a result held over a frozen stretch is written and reported on the enabled cycle
    // that follows, never while frozen
    always_comb begin
        wb       = held;
        wb.wr_en = held.wr_en & cpu_en;
    end

endmodule

`default_nettype wire

// ==== hdl/alu_execute.sv ====
`default_nettype none

`include "mips_settings.svh"

module alu_execute (
    input  wire  mips_pkg::id_ex_t     ex_in,
    output mips_pkg::reg_write_t       ex_result
);

    logic [`MIPS_DATA_W-1:0] op_a;
    logic [`MIPS_DATA_W-1:0] op_b;
    logic [`MIPS_DATA_W-1:0] alu_out;

    assign op_a = ex_in.use_shamt ? ex_in.rt_val : ex_in.rs_val; // shifts move rt
    assign op_b = ex_in.use_imm ? ex_in.imm : ex_in.rt_val;

    always_comb begin
        case (ex_in.alu_op)
            mips_pkg::ALU_ADD: alu_out = op_a + op_b;
            mips_pkg::ALU_SUB: alu_out = op_a - op_b;
            mips_pkg::ALU_AND: alu_out = op_a & op_b;
            mips_pkg::ALU_OR:  alu_out = op_a | op_b;
            mips_pkg::ALU_XOR: alu_out = op_a ^ op_b;
            mips_pkg::ALU_SLT: begin
                alu_out = {{(`MIPS_DATA_W-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            mips_pkg::ALU_SLL: alu_out = op_a << ex_in.shamt;
            mips_pkg::ALU_SRL: alu_out = op_a >> ex_in.shamt; // logical, zero fill
            default:           alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        ex_result         = '0;
        ex_result.wr_en   = ex_in.wr_en;
        ex_result.wr_addr = ex_in.wr_addr;
        ex_result.data    = alu_out;
    end

endmodule

`default_nettype wire

// ==== hdl/id_ex_regs.sv ====
`default_nettype none

module id_ex_regs (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          cpu_en,
    input  wire                          stall,
    input  wire       mips_pkg::id_ex_t  id_out,
    output mips_pkg::id_ex_t             ex_in
);

    // all fields zero, so wr_en is low and the ALU adds zeros
    localparam mips_pkg::id_ex_t bubble = '0;

    mips_pkg::id_ex_t next_ex;

    // a stalled instruction stays in decode while execute gets a bubble
    assign next_ex = stall ? bubble : id_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_in <= bubble;
        end else if (cpu_en) begin
            ex_in <= next_ex;
        end
        // with cpu_en low the stage keeps its contents
    end

endmodule

`default_nettype wire

// ==== hdl/instr_decode.sv ====
`default_nettype none

`include "mips_settings.svh"

module instr_decode (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire        [`MIPS_DATA_W-1:0]    instr,
    input  wire        mips_pkg::reg_write_t wb,
    input  wire                              ex_wr_en,
    input  wire        [`MIPS_REG_ADDR_W-1:0] ex_wr_addr,
    output mips_pkg::id_ex_t                 id_out,
    output logic                             stall
);

    logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_COUNT];

    mips_pkg::opcode_e           op;
    mips_pkg::funct_e            fn;
    logic [`MIPS_REG_ADDR_W-1:0] rs_addr;
    logic [`MIPS_REG_ADDR_W-1:0] rt_addr;
    logic [`MIPS_REG_ADDR_W-1:0] rd_addr;
    logic [`MIPS_REG_ADDR_W-1:0] shamt;
    logic [15:0]                 imm16;
    logic [`MIPS_DATA_W-1:0]     rs_val;
    logic [`MIPS_DATA_W-1:0]     rt_val;
    logic                        rs_addr_used;
    logic                        rt_addr_used;

    assign op      = mips_pkg::opcode_e'(instr[31:26]);
    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign rd_addr = instr[15:11];
    assign shamt   = instr[10:6];
    assign fn      = mips_pkg::funct_e'(instr[5:0]);
    assign imm16   = instr[15:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wr_en) begin
            regs[wb.wr_addr] <= wb.data; // wr_en is never set for register 0
        end
    end

    // the result being written this cycle bypasses the array
    assign rs_val = (wb.wr_en && wb.wr_addr == rs_addr) ? wb.data : regs[rs_addr];
    assign rt_val = (wb.wr_en && wb.wr_addr == rt_addr) ? wb.data : regs[rt_addr];

    always_comb begin
        id_out        = '0;
        id_out.rs_val = rs_val;
        id_out.rt_val = rt_val;
        id_out.shamt  = shamt;
        rs_addr_used  = 1'b0;
        rt_addr_used  = 1'b0;
        case (op)
            mips_pkg::OP_RTYPE: begin
                id_out.wr_en   = 1'b1;
                id_out.wr_addr = rd_addr;
                rs_addr_used   = 1'b1;
                rt_addr_used   = 1'b1;
                case (fn)
                    mips_pkg::FN_ADD: id_out.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: id_out.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: id_out.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  id_out.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR: id_out.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT: id_out.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL, mips_pkg::FN_SRL: begin
                        // shifts read rt only, rs is ignored
                        id_out.alu_op    = (fn == mips_pkg::FN_SLL) ? mips_pkg::ALU_SLL
                                                                    : mips_pkg::ALU_SRL;
                        id_out.use_shamt = 1'b1;
                        rs_addr_used     = 1'b0;
                    end
                    default: begin
                        id_out.wr_en = 1'b0; // unknown funct behaves as a nop
                        rs_addr_used = 1'b0;
                        rt_addr_used = 1'b0;
                    end
                endcase
            end
            mips_pkg::OP_ADDI: begin
                id_out.alu_op  = mips_pkg::ALU_ADD;
                id_out.use_imm = 1'b1;
                id_out.imm     = {{(`MIPS_DATA_W-16){imm16[15]}}, imm16};
                id_out.wr_en   = 1'b1;
                id_out.wr_addr = rt_addr;
                rs_addr_used   = 1'b1;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI: begin
                id_out.alu_op  = (op == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND
                                                           : mips_pkg::ALU_OR;
                id_out.use_imm = 1'b1;
                id_out.imm     = {{(`MIPS_DATA_W-16){1'b0}}, imm16};
                id_out.wr_en   = 1'b1;
                id_out.wr_addr = rt_addr;
                rs_addr_used   = 1'b1;
            end
            default: id_out.wr_en = 1'b0;
        endcase
        if (id_out.wr_addr == '0) begin
            id_out.wr_en = 1'b0; // also turns the all-zero word into a nop
        end
    end

    // no forwarding from execute, so wait one slot for the producer to reach the write port
    assign stall = ex_wr_en && (ex_wr_addr != '0) &&
                   ((rs_addr_used && rs_addr == ex_wr_addr) ||
                    (rt_addr_used && rt_addr == ex_wr_addr));

endmodule

`default_nettype wire

// ==== hdl/mips_pkg.sv ====
`default_nettype none

`include "mips_settings.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd8,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL = 6'd0,
        FN_SRL = 6'd2,
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_XOR = 6'd38,
        FN_SLT = 6'd42
    } funct_e;

    // ALU_ADD stays at zero so that an all-zero bubble is a harmless add
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef struct packed {
        logic [`MIPS_DATA_W-1:0]     rs_val;
        logic [`MIPS_DATA_W-1:0]     rt_val;
        logic [`MIPS_DATA_W-1:0]     imm;       // already extended
        logic [`MIPS_REG_ADDR_W-1:0] shamt;
        alu_op_e                     alu_op;
        logic                        use_shamt; // shift rt_val by shamt
        logic                        use_imm;   // operand b is imm instead of rt_val
        logic                        wr_en;
        logic [`MIPS_REG_ADDR_W-1:0] wr_addr;
    } id_ex_t;

    typedef struct packed {
        logic                        wr_en;
        logic [`MIPS_REG_ADDR_W-1:0] wr_addr;
        logic [`MIPS_DATA_W-1:0]     data;
    } reg_write_t;

endpackage

`default_nettype wire

// ==== hdl/mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// one machine word, also the width of every register and immediate after extension
`define MIPS_DATA_W 32

// general registers, register 0 always reads as zero
`define MIPS_REG_COUNT 32

// width of the rs, rt, rd and shamt fields
`define MIPS_REG_ADDR_W 5

`endif
